// File: src/huff_hdr_pkg.sv
`default_nettype none

package huff_hdr_pkg;

    // tree table geometry
    localparam int node_addr_w = 6;              // node index width
    localparam int num_nodes   = 64;             // table depth, root lives at 0
    localparam int char_w      = 8;              // leaf character width
    localparam int max_depth   = 16;             // deepest path the walker stack holds
    localparam int track_w     = 5;              // path depth counter, 0..max_depth
    localparam int count_w     = 8;              // left count field width

    // node word, msb first: is_leaf | character | left child | right child
    localparam int node_w    = 1 + char_w + 2 * node_addr_w;
    localparam int leaf_bit  = node_w - 1;
    localparam int char_lsb  = 2 * node_addr_w;
    localparam int left_lsb  = node_addr_w;
    localparam int right_lsb = 0;

    // header fields carry a leading 1 ahead of the 8 payload bits
    localparam int hdr_bits  = 1 + char_w;
    localparam int hdr_cnt_w = 4;                // wide enough to hold hdr_bits

endpackage

`default_nettype wire

// File: src/huff_tree_walker.sv
`timescale 1ns/1ps
`default_nettype none

module huff_tree_walker
    import huff_hdr_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   node_we,
    input  logic [node_addr_w-1:0] node_addr,
    input  logic [node_w-1:0]      node_wdata,
    input  logic                   busy,
    output logic                   char_found,
    output logic [char_w-1:0]      char_index,
    output logic                   left,
    output logic [count_w-1:0]     num_lefts,
    output logic                   backtrack,
    output logic                   walking,
    output logic                   walk_end
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_descend,
        st_report,
        st_climb,
        st_drain
    } state_t;

    state_t state;

    logic [node_w-1:0]      node_mem [num_nodes];
    logic [node_addr_w-1:0] stk_node [max_depth];  // parent index per level
    logic                   stk_dir  [max_depth];  // 1 once the walk went right

    logic [track_w-1:0]     sp;                    // path depth, entries on the stack
    logic [track_w-2:0]     top;                   // index of the newest entry
    logic [node_addr_w-1:0] cur;                   // node being visited
    logic [count_w-1:0]     lefts;                 // left edges on the current path
    logic                   busy_d;
    logic                   stall;

    logic [node_w-1:0]      node;                  // word of the current node
    logic [node_addr_w-1:0] parent;
    logic                   top_dir;
    logic [node_addr_w-1:0] sibling;               // right child of the parent

    assign top     = sp[track_w-2:0] - 1'b1;
    assign node    = node_mem[cur];
    assign parent  = stk_node[top];
    assign top_dir = stk_dir[top];
    assign sibling = node_mem[parent][right_lsb +: node_addr_w];

    // synthesis needs a quiet cycle after it drops busy
    assign stall = busy | busy_d;

    assign walking    = (state != st_idle);
    assign char_found = (state == st_report) && !stall;
    assign backtrack  = (state == st_climb) && !stall && (sp != '0) && top_dir;
    assign walk_end   = (state == st_drain) && !stall;

    assign char_index = node[char_lsb +: char_w];
    assign left       = (sp != '0) && !top_dir;    // leaf reached over a left edge
    assign num_lefts  = lefts;

    // host loads the table between walks
    always_ff @(posedge clk) begin
        if (node_we) begin
            node_mem[node_addr] <= node_wdata;
        end
    end

    // path stack, pushed on descend and turned right in climb
    always_ff @(posedge clk) begin
        if (state == st_descend && !stall) begin
            stk_node[sp[track_w-2:0]] <= cur;
            stk_dir[sp[track_w-2:0]]  <= 1'b0;
        end else if (state == st_climb && !stall && sp != '0 && !top_dir) begin
            stk_dir[top] <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= st_idle;
            sp     <= '0;
            cur    <= '0;
            lefts  <= '0;
            busy_d <= 1'b0;
        end else begin
            busy_d <= busy;
            case (state)
                st_idle: begin
                    if (start) begin
                        cur   <= '0;                    // root
                        sp    <= '0;
                        lefts <= '0;
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (!stall) begin
                        state <= node[leaf_bit] ? st_report : st_descend;
                    end
                end
                st_descend: begin
                    if (!stall) begin
                        sp    <= sp + 1'b1;
                        cur   <= node[left_lsb +: node_addr_w];
                        lefts <= lefts + 1'b1;
                        state <= st_fetch;
                    end
                end
                st_report: begin
                    if (!stall) begin
                        state <= st_climb;
                    end
                end
                st_climb: begin
                    if (!stall) begin
                        if (sp == '0) begin
                            state <= st_drain;          // back at the root
                        end else if (top_dir) begin
                            sp  <= sp - 1'b1;           // climb one right edge
                            cur <= parent;
                        end else begin
                            cur   <= sibling;           // left subtree done, go right
                            lefts <= lefts - 1'b1;
                            state <= st_fetch;
                        end
                    end
                end
                st_drain: begin
                    if (!stall) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // a push at full depth would overwrite a live entry
    a_stack_depth: assert property (@(posedge clk) disable iff (rst)
        !(state == st_descend && !stall && sp == track_w'(max_depth)));

    // busy from synthesis has to be up before the next event can leave
    a_one_event: assert property (@(posedge clk) disable iff (rst)
        char_found |=> !(char_found || backtrack));

endmodule

`default_nettype wire

// File: src/header_synthesis.sv
`timescale 1ns/1ps
`default_nettype none

module header_synthesis
    import huff_hdr_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [char_w-1:0]  char_index,
    input  logic               char_found,
    input  logic               left,         // leaf is a left child
    input  logic [count_w-1:0] num_lefts,    // left edges on the leaf path
    input  logic               backtrack,
    input  logic               walking,
    output logic               enable,       // bit1 carries a header bit
    output logic               bit1,
    output logic               busy
);

    logic [hdr_bits-1:0]  header;            // shift register, msb goes out first
    logic [hdr_cnt_w-1:0] count;             // bits of the current field sent
    logic                 write_char_path;
    logic                 write_num_lefts;
    logic                 write_zeroes;
    logic                 shifting;
    logic                 last_bit;
    logic                 add_lefts;

    logic                 left_q;            // leaf info held across the header
    logic [count_w-1:0]   lefts_q;

    assign shifting = write_char_path | write_num_lefts;
    assign last_bit = shifting && (count == hdr_cnt_w'(hdr_bits - 1));

    // left leaves follow their header with the count of left edges
    assign add_lefts = left_q && (lefts_q != '0);

    // one zero per right edge climbed, only between headers
    assign write_zeroes = backtrack && walking && !shifting && !char_found;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable          <= 1'b0;
            bit1            <= 1'b0;
            busy            <= 1'b0;
            count           <= '0;
            write_char_path <= 1'b0;
            write_num_lefts <= 1'b0;
        end else begin
            enable <= 1'b0;
            bit1   <= 1'b0;
            if (char_found) begin
                write_char_path <= 1'b1;             // header goes out from next cycle
                write_num_lefts <= 1'b0;
                count           <= '0;
                busy            <= 1'b1;
            end else if (shifting) begin
                enable <= 1'b1;
                bit1   <= header[hdr_bits-1];
                busy   <= 1'b1;                      // stays up through the last bit
                if (last_bit) begin
                    count <= '0;
                    if (write_char_path && add_lefts) begin
                        write_char_path <= 1'b0;
                        write_num_lefts <= 1'b1;     // count field runs straight after
                    end else begin
                        write_char_path <= 1'b0;
                        write_num_lefts <= 1'b0;
                    end
                end else begin
                    count <= count + 1'b1;
                end
            end else if (write_zeroes) begin
                enable <= 1'b1;
                bit1   <= 1'b0;
                busy   <= 1'b0;
            end else begin
                busy <= 1'b0;                        // drops the cycle after the last bit
            end
        end
    end

    // payload side of the shifter
    always_ff @(posedge clk) begin
        if (char_found) begin
            header  <= {1'b1, char_index};
            left_q  <= left;
            lefts_q <= num_lefts;
        end else if (shifting) begin
            if (last_bit && write_char_path) begin
                header <= {1'b1, lefts_q};           // reload with the left count field
            end else begin
                header <= {header[hdr_bits-2:0], 1'b0};
            end
        end
    end

    // a backtrack zero must not land inside a field being shifted
    a_zero_quiet: assert property (@(posedge clk) disable iff (rst)
        !(backtrack && busy));

    // the walker has to hold its next leaf until the header is out
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(char_found && busy));

endmodule

`default_nettype wire

// File: src/header_packer.sv
`timescale 1ns/1ps
`default_nettype none

module header_packer (
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  logic       bit1,
    input  logic       walk_end,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       done
);

    logic [7:0] shreg;                       // bits collected, newest in the lsb
    logic [7:0] shreg_next;
    logic [2:0] fill;                        // bits held in the current byte
    logic       done_pend;                   // done waits one cycle behind the flush

    assign shreg_next = {shreg[6:0], bit1};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill       <= '0;
            byte_valid <= 1'b0;
            done       <= 1'b0;
            done_pend  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            done       <= done_pend;
            done_pend  <= 1'b0;
            if (enable) begin
                fill <= fill + 3'd1;
                if (fill == 3'd7) begin
                    byte_valid <= 1'b1;      // 8th bit completes a byte
                end
            end else if (walk_end) begin
                if (fill != '0) begin
                    byte_valid <= 1'b1;      // padded last byte
                    done_pend  <= 1'b1;
                    fill       <= '0;
                end else begin
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            shreg <= shreg_next;
            if (fill == 3'd7) begin
                byte_data <= shreg_next;
            end
        end else if (walk_end && fill != '0) begin
            byte_data <= shreg << (4'd8 - {1'b0, fill});   // align to msb, zero fill
        end
    end

    // the walker flags the end only once the stream has gone quiet
    a_end_quiet: assert property (@(posedge clk) disable iff (rst)
        !(walk_end && enable));

endmodule

`default_nettype wire

// File: src/huff_header_gen.sv
`timescale 1ns/1ps
`default_nettype none

module huff_header_gen
    import huff_hdr_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   node_we,
    input  logic [node_addr_w-1:0] node_addr,
    input  logic [node_w-1:0]      node_wdata,
    output logic                   byte_valid,
    output logic [7:0]             byte_data,
    output logic                   done
);

    // walker events
    logic               char_found;
    logic [char_w-1:0]  char_index;
    logic               left;
    logic [count_w-1:0] num_lefts;
    logic               backtrack;
    logic               walking;
    logic               walk_end;

    // synthesis stream
    logic               busy;
    logic               enable;
    logic               bit1;

    huff_tree_walker huff_tree_walker_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .node_we    (node_we),
        .node_addr  (node_addr),
        .node_wdata (node_wdata),
        .busy       (busy),
        .char_found (char_found),
        .char_index (char_index),
        .left       (left),
        .num_lefts  (num_lefts),
        .backtrack  (backtrack),
        .walking    (walking),
        .walk_end   (walk_end)
    );

    header_synthesis header_synthesis_inst (
        .clk        (clk),
        .rst        (rst),
        .char_index (char_index),
        .char_found (char_found),
        .left       (left),
        .num_lefts  (num_lefts),
        .backtrack  (backtrack),
        .walking    (walking),
        .enable     (enable),
        .bit1       (bit1),
        .busy       (busy)
    );

    header_packer header_packer_inst (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .bit1       (bit1),
        .walk_end   (walk_end),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .done       (done)
    );

endmodule

`default_nettype wire

// File: verif/tb_huff_header_tasks.svh
task automatic load_tree();
    for (int i = 0; i < n_nodes; i++) begin
        @(negedge clk);
        node_we    = 1'b1;
        node_addr  = node_addr_w'(i);
        node_wdata = {t_leaf[i], t_char[i], node_addr_w'(t_left[i]), node_addr_w'(t_right[i])};
    end
    @(negedge clk);
    node_we = 1'b0;
endtask

// extra_start picks a cycle for a second start pulse, -1 for none
task automatic run_and_collect(input int extra_start);
    int cyc;
    bit seen_done;
    got_bytes.delete();
    cyc       = 0;
    seen_done = 1'b0;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!seen_done && cyc < 20000) begin
        if (byte_valid) begin
            got_bytes.push_back(byte_data);
            $display("byte %0d: %h", got_bytes.size() - 1, byte_data);
        end
        if (done) begin
            seen_done = 1'b1;
        end
        start = (cyc == extra_start);
        @(negedge clk);
        cyc++;
    end
    start = 1'b0;
    assert (seen_done) else begin
        $display("timeout while waiting for done");
        errors++;
    end
endtask

task automatic check_stream();
    int n;
    build_expected();
    assert (got_bytes.size() == exp_bytes.size()) else begin
        $display("byte count is %0d, model gives %0d", got_bytes.size(), exp_bytes.size());
        errors++;
    end
    n = (got_bytes.size() < exp_bytes.size()) ? got_bytes.size() : exp_bytes.size();
    for (int i = 0; i < n; i++) begin
        assert (got_bytes[i] == exp_bytes[i]) else begin
            $display("[FAIL] byte_data[%0d] expected %h got %h", i, exp_bytes[i], got_bytes[i]);
            errors++;
        end
    end
endtask

function automatic int build_balanced(input int depth);
    int idx;
    idx = alloc_node(depth == 0);
    if (depth != 0) begin
        t_left[idx]  = build_balanced(depth - 1);
        t_right[idx] = build_balanced(depth - 1);
    end
    return idx;
endfunction

function automatic int build_skew(input int depth, input bit go_left);
    int idx;
    idx = alloc_node(depth == 0);
    if (depth != 0) begin
        if (go_left) begin
            t_left[idx]  = build_skew(depth - 1, go_left);
            t_right[idx] = alloc_node(1'b1);
        end else begin
            t_left[idx]  = alloc_node(1'b1);
            t_right[idx] = build_skew(depth - 1, go_left);
        end
    end
    return idx;
endfunction

function automatic int build_random(input int depth);
    int idx;
    bit leaf;
    leaf = (depth >= 5) || (n_nodes > 48) || (depth > 0 && rand_bits(2) == 0);
    idx  = alloc_node(leaf);
    if (!leaf) begin
        t_left[idx]  = build_random(depth + 1);
        t_right[idx] = build_random(depth + 1);
    end
    return idx;
endfunction

task automatic new_tree(input int kind);
    n_nodes = 0;
    case (kind)
        0: void'(build_balanced(1));
        1: void'(build_skew(8, 1'b1));
        2: void'(build_balanced(3));
        3: void'(build_skew(8, 1'b0));
        default: void'(build_random(0));
    endcase
    load_tree();
endtask

task automatic test_two_leaves();
    n_nodes = 0;
    void'(build_balanced(1));
    t_char[1] = 8'h41;
    t_char[2] = 8'h42;
    load_tree();
    run_and_collect(-1);
    check_stream();
endtask

task automatic test_left_skew();
    new_tree(1);
    run_and_collect(-1);
    check_stream();
endtask

task automatic test_balanced();
    new_tree(2);
    run_and_collect(-1);
    check_stream();
endtask

task automatic test_right_skew();
    new_tree(3);
    run_and_collect(-1);
    check_stream();
endtask

task automatic test_restart();
    new_tree(4);
    run_and_collect(5);                         // second start lands mid walk
    check_stream();
    new_tree(4);
    run_and_collect(-1);
    check_stream();
endtask

task automatic test_reset_mid_walk();
    int cyc;
    new_tree(2);
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    cyc = 0;
    while (!byte_valid && cyc < 2000) begin
        @(negedge clk);
        cyc++;
    end
    assert (cyc < 2000) else begin
        $display("no byte seen before the reset");
        errors++;
    end
    rst = 1'b1;
    for (int i = 0; i < 4; i++) begin
        @(negedge clk);
        assert (!byte_valid && !done) else begin
            $display("[FAIL] byte_valid %h done %h during reset", byte_valid, done);
            errors++;
        end
    end
    rst = 1'b0;
    run_and_collect(-1);
    check_stream();
endtask

// File: verif/tb_huff_header_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_huff_header_gen
    import huff_hdr_pkg::*;
();

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   node_we;
    logic [node_addr_w-1:0] node_addr;
    logic [node_w-1:0]      node_wdata;
    logic                   byte_valid;
    logic [7:0]             byte_data;
    logic                   done;

    int          errors;
    logic [31:0] lfsr;                          // galois lfsr state

    // tree model, one entry per table address
    bit          t_leaf  [num_nodes];
    logic [7:0]  t_char  [num_nodes];
    int          t_left  [num_nodes];
    int          t_right [num_nodes];
    int          n_nodes;

    bit          exp_bits[$];                   // expected header stream
    logic [7:0]  exp_bytes[$];
    logic [7:0]  got_bytes[$];

    huff_header_gen huff_header_gen_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .node_we    (node_we),
        .node_addr  (node_addr),
        .node_wdata (node_wdata),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .done       (done)
    );

    always #50 clk = ~clk;

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic int alloc_node(input bit leaf);
        int idx;
        idx          = n_nodes;
        n_nodes      = n_nodes + 1;
        t_leaf[idx]  = leaf;
        t_char[idx]  = leaf ? 8'(rand_bits(8)) : 8'h00;
        t_left[idx]  = 0;
        t_right[idx] = 0;
        return idx;
    endfunction

    function automatic void push_field(input logic [7:0] value);
        exp_bits.push_back(1'b1);               // leading 1 of every field
        for (int i = 7; i >= 0; i--) begin
            exp_bits.push_back(value[i]);
        end
    endfunction

    // preorder walk, a zero follows each finished right subtree
    function automatic void model_visit(input int idx, input int lefts, input bit is_left);
        if (t_leaf[idx]) begin
            push_field(t_char[idx]);
            if (is_left && lefts != 0) begin
                push_field(8'(lefts));
            end
        end else begin
            model_visit(t_left[idx], lefts + 1, 1'b1);
            model_visit(t_right[idx], lefts, 1'b0);
            exp_bits.push_back(1'b0);
        end
    endfunction

    function automatic void build_expected();
        logic [7:0] b;
        int         k;
        exp_bits.delete();
        exp_bytes.delete();
        model_visit(0, 0, 1'b0);
        k = 0;
        b = '0;
        foreach (exp_bits[i]) begin
            b = {b[6:0], exp_bits[i]};
            k++;
            if (k == 8) begin
                exp_bytes.push_back(b);
                k = 0;
                b = '0;
            end
        end
        if (k != 0) begin
            exp_bytes.push_back(b << (8 - k));  // zero padded last byte
        end
    endfunction

    `include "tb_huff_header_tasks.svh"

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        node_we    = 1'b0;
        node_addr  = '0;
        node_wdata = '0;
        errors     = 0;
        lfsr       = 32'd74073;
        n_nodes    = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        test_two_leaves();
        test_left_skew();
        test_balanced();
        test_right_skew();
        test_restart();
        test_reset_mid_walk();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: huff_header_gen.f
+incdir+verif
src/huff_hdr_pkg.sv
src/huff_tree_walker.sv
src/header_synthesis.sv
src/header_packer.sv
src/huff_header_gen.sv
verif/tb_huff_header_gen.sv

// File: Makefile
TOP = tb_huff_header_gen

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f huff_header_gen.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f huff_header_gen.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir
